// ==== design/rs_config.svh ====
`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

// operand and result width
`define RS_XLEN 32

// physical register file size
`define RS_PRF 32

// station depth
`define RS_ENTRIES 8

// dispatch width, lane count and cdb ways
`define RS_WAYS 2

// mul issue to cdb result
`define RS_MUL_CYCLES 3

// two-bit operation codes
`define RS_OP_ADD 2'd0
`define RS_OP_SUB 2'd1
`define RS_OP_XOR 2'd2
`define RS_OP_MUL 2'd3

`endif

// ==== design/rs_types_pkg.sv ====
`include "rs_config.svh"

package rs_types_pkg;

    // one data word
    typedef logic [`RS_XLEN-1:0] xlen_t;

    // physical register index
    typedef logic [$clog2(`RS_PRF)-1:0] prf_tag_t;

    // add, sub, xor or mul
    typedef logic [1:0] alu_op_t;

    // 0 up to RS_ENTRIES inclusive, hence the +1
    typedef logic [$clog2(`RS_ENTRIES+1)-1:0] rs_count_t;

endpackage

// ==== design/rs_ctrl_pkg.sv ====
package rs_ctrl_pkg;

    // station entry life cycle
    typedef enum logic [1:0] {
        ENTRY_FREE,
        ENTRY_WAIT,
        ENTRY_READY
    } entry_state_t;

    // lane is either free each cycle or counting down a mul
    typedef enum logic {
        LANE_IDLE,
        LANE_MUL
    } lane_state_t;

endpackage

// ==== design/dispatch_if.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

interface dispatch_if import rs_types_pkg::*; ();

    // one strobe per way, captured on the same edge
    logic [`RS_WAYS-1:0]    valid;
    alu_op_t [`RS_WAYS-1:0] op;
    prf_tag_t [`RS_WAYS-1:0] dest_tag;

    // value when ready, producer tag in low bits otherwise
    logic [`RS_WAYS-1:0]    opa_ready;
    xlen_t [`RS_WAYS-1:0]   opa;
    logic [`RS_WAYS-1:0]    opb_ready;
    xlen_t [`RS_WAYS-1:0]   opb;

    // dispatch stage side
    modport source (
        output valid, op, dest_tag, opa_ready, opa, opb_ready, opb
    );

    // station side
    modport sink (
        input valid, op, dest_tag, opa_ready, opa, opb_ready, opb
    );

endinterface

// ==== design/issue_if.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

interface issue_if import rs_types_pkg::*; ();

    // one instruction per valid pulse per lane
    logic [`RS_WAYS-1:0]     valid;
    alu_op_t [`RS_WAYS-1:0]  op;
    xlen_t [`RS_WAYS-1:0]    opa;
    xlen_t [`RS_WAYS-1:0]    opb;
    prf_tag_t [`RS_WAYS-1:0] dest_tag;

    // lane cannot take anything this cycle
    logic [`RS_WAYS-1:0]     busy;

    // station side
    modport source (
        output valid, op, opa, opb, dest_tag,
        input  busy
    );

    // execution lane side
    modport sink (
        input  valid, op, opa, opb, dest_tag,
        output busy
    );

endinterface

// ==== design/dispatch_stage.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module dispatch_stage import rs_types_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [`RS_WAYS-1:0]     disp_valid,
    input  alu_op_t [`RS_WAYS-1:0]  disp_op,
    input  prf_tag_t [`RS_WAYS-1:0] disp_src1_tag,
    input  prf_tag_t [`RS_WAYS-1:0] disp_src2_tag,
    input  logic [`RS_WAYS-1:0]     disp_use_imm,
    input  xlen_t [`RS_WAYS-1:0]    disp_imm,
    input  prf_tag_t [`RS_WAYS-1:0] disp_dest_tag,
    input  logic [`RS_WAYS-1:0]     cdb_valid,
    input  prf_tag_t [`RS_WAYS-1:0] cdb_tag,
    input  xlen_t [`RS_WAYS-1:0]    cdb_data,
    dispatch_if.source              dsp
);

    // scoreboard, one ready bit and value per physical register
    logic [`RS_PRF-1:0] prf_ready;
    xlen_t              prf_value [`RS_PRF];

    always_ff @(posedge clock) begin
        if (reset) begin
            prf_ready <= '1;
            for (int r = 0; r < `RS_PRF; r++) begin
                prf_value[r] <= '0;
            end
        end else begin
            // results arriving on the cdb
            for (int c = 0; c < `RS_WAYS; c++) begin
                if (cdb_valid[c]) begin
                    prf_ready[cdb_tag[c]] <= 1'b1;
                    prf_value[cdb_tag[c]] <= cdb_data[c];
                end
            end
            // new producer makes the destination pending again
            for (int w = 0; w < `RS_WAYS; w++) begin
                if (disp_valid[w]) begin
                    prf_ready[disp_dest_tag[w]] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        logic  a_rdy;
        logic  b_rdy;
        xlen_t a_val;
        xlen_t b_val;
        for (int w = 0; w < `RS_WAYS; w++) begin
            // scoreboard first, tag otherwise
            a_rdy = prf_ready[disp_src1_tag[w]];
            a_val = a_rdy ? prf_value[disp_src1_tag[w]] : xlen_t'(disp_src1_tag[w]);
            b_rdy = prf_ready[disp_src2_tag[w]];
            b_val = b_rdy ? prf_value[disp_src2_tag[w]] : xlen_t'(disp_src2_tag[w]);
            // same-cycle cdb bypass
            for (int c = 0; c < `RS_WAYS; c++) begin
                if (!a_rdy && cdb_valid[c] && cdb_tag[c] == disp_src1_tag[w]) begin
                    a_rdy = 1'b1;
                    a_val = cdb_data[c];
                end
                if (!b_rdy && cdb_valid[c] && cdb_tag[c] == disp_src2_tag[w]) begin
                    b_rdy = 1'b1;
                    b_val = cdb_data[c];
                end
            end
            // older way in the same group produces it, so wait for its tag
            for (int p = 0; p < w; p++) begin
                if (disp_valid[p] && disp_dest_tag[p] == disp_src1_tag[w]) begin
                    a_rdy = 1'b0;
                    a_val = xlen_t'(disp_src1_tag[w]);
                end
                if (disp_valid[p] && disp_dest_tag[p] == disp_src2_tag[w]) begin
                    b_rdy = 1'b0;
                    b_val = xlen_t'(disp_src2_tag[w]);
                end
            end
            // immediate replaces operand b
            if (disp_use_imm[w]) begin
                b_rdy = 1'b1;
                b_val = disp_imm[w];
            end
            dsp.valid[w]     = disp_valid[w];
            dsp.op[w]        = disp_op[w];
            dsp.dest_tag[w]  = disp_dest_tag[w];
            dsp.opa_ready[w] = a_rdy;
            dsp.opa[w]       = a_val;
            dsp.opb_ready[w] = b_rdy;
            dsp.opb[w]       = b_val;
        end
    end

endmodule

// ==== design/rs_entry.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_entry
    import rs_types_pkg::*;
    import rs_ctrl_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    load,
    input  alu_op_t                 ld_op,
    input  prf_tag_t                ld_dest_tag,
    input  logic                    ld_opa_ready,
    input  xlen_t                   ld_opa,
    input  logic                    ld_opb_ready,
    input  xlen_t                   ld_opb,
    input  logic                    release_en,
    input  logic [`RS_WAYS-1:0]     cdb_valid,
    input  prf_tag_t [`RS_WAYS-1:0] cdb_tag,
    input  xlen_t [`RS_WAYS-1:0]    cdb_data,
    output entry_state_t            state,
    output alu_op_t                 op,
    output prf_tag_t                dest_tag,
    output xlen_t                   opa,
    output xlen_t                   opb
);

    logic  opa_ready;
    logic  opb_ready;
    logic  opa_ready_nxt;
    logic  opb_ready_nxt;
    xlen_t opa_nxt;
    xlen_t opb_nxt;

    // wakeup, unknown operands hold their tag in the low bits
    always_comb begin
        opa_ready_nxt = opa_ready;
        opb_ready_nxt = opb_ready;
        opa_nxt       = opa;
        opb_nxt       = opb;
        for (int c = 0; c < `RS_WAYS; c++) begin
            if (!opa_ready && cdb_valid[c] && cdb_tag[c] == prf_tag_t'(opa)) begin
                opa_ready_nxt = 1'b1;
                opa_nxt       = cdb_data[c];
            end
            if (!opb_ready && cdb_valid[c] && cdb_tag[c] == prf_tag_t'(opb)) begin
                opb_ready_nxt = 1'b1;
                opb_nxt       = cdb_data[c];
            end
        end
    end

    // control
    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= ENTRY_FREE;
            opa_ready <= 1'b0;
            opb_ready <= 1'b0;
        end else if (release_en) begin
            state <= ENTRY_FREE;
        end else if (load) begin
            opa_ready <= ld_opa_ready;
            opb_ready <= ld_opb_ready;
            state     <= (ld_opa_ready && ld_opb_ready) ? ENTRY_READY : ENTRY_WAIT;
        end else if (state == ENTRY_WAIT) begin
            opa_ready <= opa_ready_nxt;
            opb_ready <= opb_ready_nxt;
            if (opa_ready_nxt && opb_ready_nxt) begin
                state <= ENTRY_READY;
            end
        end
    end

    // payload
    always_ff @(posedge clock) begin
        if (load) begin
            op       <= ld_op;
            dest_tag <= ld_dest_tag;
            opa      <= ld_opa;
            opb      <= ld_opb;
        end else if (state == ENTRY_WAIT) begin
            opa <= opa_nxt;
            opb <= opb_nxt;
        end
    end

endmodule

// ==== design/reservation_station.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module reservation_station
    import rs_types_pkg::*;
    import rs_ctrl_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    dispatch_if.sink                dsp,
    issue_if.source                 iss,
    input  logic [`RS_WAYS-1:0]     cdb_valid,
    input  prf_tag_t [`RS_WAYS-1:0] cdb_tag,
    input  xlen_t [`RS_WAYS-1:0]    cdb_data,
    output rs_count_t               free_count
);

    localparam int WAY_W = (`RS_WAYS > 1) ? $clog2(`RS_WAYS) : 1;

    // per-entry views
    entry_state_t           ent_state [`RS_ENTRIES];
    alu_op_t                ent_op    [`RS_ENTRIES];
    prf_tag_t               ent_dest  [`RS_ENTRIES];
    xlen_t                  ent_opa   [`RS_ENTRIES];
    xlen_t                  ent_opb   [`RS_ENTRIES];
    logic [`RS_ENTRIES-1:0] load_vec;
    logic [`RS_ENTRIES-1:0] release_vec;
    logic [WAY_W-1:0]       way_of    [`RS_ENTRIES];
    rs_count_t              alloc_cnt;
    rs_count_t              rel_cnt;

    // allocation, way 0 takes the lowest free entry, way 1 the next
    always_comb begin
        logic placed;
        load_vec  = '0;
        alloc_cnt = '0;
        for (int e = 0; e < `RS_ENTRIES; e++) begin
            way_of[e] = '0;
        end
        for (int w = 0; w < `RS_WAYS; w++) begin
            placed = 1'b0;
            for (int e = 0; e < `RS_ENTRIES; e++) begin
                if (dsp.valid[w] && !placed && !load_vec[e] && ent_state[e] == ENTRY_FREE) begin
                    placed      = 1'b1;
                    load_vec[e] = 1'b1;
                    way_of[e]   = WAY_W'(w);
                    alloc_cnt   = alloc_cnt + rs_count_t'(1);
                end
            end
            // no free entry left, way is dropped
        end
    end

    // select, ready entries in index order go to the next non-busy lane
    always_comb begin
        logic [`RS_WAYS-1:0] lane_taken;
        lane_taken   = iss.busy;
        release_vec  = '0;
        rel_cnt      = '0;
        iss.valid    = '0;
        iss.op       = '0;
        iss.opa      = '0;
        iss.opb      = '0;
        iss.dest_tag = '0;
        for (int e = 0; e < `RS_ENTRIES; e++) begin
            for (int l = 0; l < `RS_WAYS; l++) begin
                if (ent_state[e] == ENTRY_READY && !release_vec[e] && !lane_taken[l]) begin
                    lane_taken[l]   = 1'b1;
                    release_vec[e]  = 1'b1;
                    iss.valid[l]    = 1'b1;
                    iss.op[l]       = ent_op[e];
                    iss.opa[l]      = ent_opa[e];
                    iss.opb[l]      = ent_opb[e];
                    iss.dest_tag[l] = ent_dest[e];
                    rel_cnt         = rel_cnt + rs_count_t'(1);
                end
            end
        end
    end

    // free count lags allocation by one edge
    always_ff @(posedge clock) begin
        if (reset) begin
            free_count <= rs_count_t'(`RS_ENTRIES);
        end else begin
            free_count <= free_count - alloc_cnt + rel_cnt;
        end
    end

    for (genvar e = 0; e < `RS_ENTRIES; e++) begin : g_entry
        rs_entry u_entry (
            .clock        (clock),
            .reset        (reset),
            .load         (load_vec[e]),
            .ld_op        (dsp.op[way_of[e]]),
            .ld_dest_tag  (dsp.dest_tag[way_of[e]]),
            .ld_opa_ready (dsp.opa_ready[way_of[e]]),
            .ld_opa       (dsp.opa[way_of[e]]),
            .ld_opb_ready (dsp.opb_ready[way_of[e]]),
            .ld_opb       (dsp.opb[way_of[e]]),
            .release_en   (release_vec[e]),
            .cdb_valid    (cdb_valid),
            .cdb_tag      (cdb_tag),
            .cdb_data     (cdb_data),
            .state        (ent_state[e]),
            .op           (ent_op[e]),
            .dest_tag     (ent_dest[e]),
            .opa          (ent_opa[e]),
            .opb          (ent_opb[e])
        );
    end

endmodule

// ==== design/exec_lanes.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module exec_lanes
    import rs_types_pkg::*;
    import rs_ctrl_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    issue_if.sink                   iss,
    output logic [`RS_WAYS-1:0]     cdb_valid,
    output prf_tag_t [`RS_WAYS-1:0] cdb_tag,
    output xlen_t [`RS_WAYS-1:0]    cdb_data
);

    localparam int CNT_W = $clog2(`RS_MUL_CYCLES + 1);

    for (genvar l = 0; l < `RS_WAYS; l++) begin : g_lane
        lane_state_t lane_state;
        logic [CNT_W-1:0] mul_cnt;
        logic        vld_q;
        prf_tag_t    tag_q;
        xlen_t       data_q;
        xlen_t       mul_a;
        xlen_t       mul_b;
        xlen_t       alu_res;
        logic        mul_done;

        // single-cycle ops
        always_comb begin
            case (iss.op[l])
                `RS_OP_ADD: alu_res = iss.opa[l] + iss.opb[l];
                `RS_OP_SUB: alu_res = iss.opa[l] - iss.opb[l];
                `RS_OP_XOR: alu_res = iss.opa[l] ^ iss.opb[l];
                default:    alu_res = '0;
            endcase
        end

        assign mul_done   = (lane_state == LANE_MUL) && (mul_cnt == CNT_W'(1));
        // busy only while a mul is in flight
        assign iss.busy[l] = (lane_state == LANE_MUL);

        always_ff @(posedge clock) begin
            if (reset) begin
                lane_state <= LANE_IDLE;
                mul_cnt    <= '0;
                vld_q      <= 1'b0;
            end else begin
                vld_q <= 1'b0;
                case (lane_state)
                    LANE_IDLE: begin
                        if (iss.valid[l] && iss.op[l] == `RS_OP_MUL) begin
                            lane_state <= LANE_MUL;
                            mul_cnt    <= CNT_W'(`RS_MUL_CYCLES - 1);
                        end else if (iss.valid[l]) begin
                            vld_q <= 1'b1;
                        end
                    end
                    LANE_MUL: begin
                        if (mul_done) begin
                            vld_q      <= 1'b1;
                            lane_state <= LANE_IDLE;
                        end else begin
                            mul_cnt <= mul_cnt - CNT_W'(1);
                        end
                    end
                    default: lane_state <= LANE_IDLE;
                endcase
            end
        end

        // result payload, low word of product for mul
        always_ff @(posedge clock) begin
            if (iss.valid[l]) begin
                tag_q  <= iss.dest_tag[l];
                mul_a  <= iss.opa[l];
                mul_b  <= iss.opb[l];
                data_q <= alu_res;
            end else if (mul_done) begin
                data_q <= mul_a * mul_b;
            end
        end

        assign cdb_valid[l] = vld_q;
        assign cdb_tag[l]   = tag_q;
        assign cdb_data[l]  = data_q;
    end

endmodule

// ==== design/rs_top.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_top import rs_types_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [`RS_WAYS-1:0]     disp_valid,
    input  alu_op_t [`RS_WAYS-1:0]  disp_op,
    input  prf_tag_t [`RS_WAYS-1:0] disp_src1_tag,
    input  prf_tag_t [`RS_WAYS-1:0] disp_src2_tag,
    input  logic [`RS_WAYS-1:0]     disp_use_imm,
    input  xlen_t [`RS_WAYS-1:0]    disp_imm,
    input  prf_tag_t [`RS_WAYS-1:0] disp_dest_tag,
    output rs_count_t               free_count,
    output logic [`RS_WAYS-1:0]     cdb_valid,
    output prf_tag_t [`RS_WAYS-1:0] cdb_tag,
    output xlen_t [`RS_WAYS-1:0]    cdb_data
);

    // producer to buffer
    dispatch_if dsp_bus ();

    // buffer to consumer
    issue_if iss_bus ();

    // operand lookup and cdb bypass
    dispatch_stage u_dispatch (
        .clock         (clock),
        .reset         (reset),
        .disp_valid    (disp_valid),
        .disp_op       (disp_op),
        .disp_src1_tag (disp_src1_tag),
        .disp_src2_tag (disp_src2_tag),
        .disp_use_imm  (disp_use_imm),
        .disp_imm      (disp_imm),
        .disp_dest_tag (disp_dest_tag),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_data      (cdb_data),
        .dsp           (dsp_bus.source)
    );

    // eight waiting entries
    reservation_station u_station (
        .clock      (clock),
        .reset      (reset),
        .dsp        (dsp_bus.sink),
        .iss        (iss_bus.source),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_data   (cdb_data),
        .free_count (free_count)
    );

    // lanes drive the cdb, which is also the top-level result
    exec_lanes u_lanes (
        .clock     (clock),
        .reset     (reset),
        .iss       (iss_bus.sink),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_data  (cdb_data)
    );

endmodule

// ==== test/rs_tb.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_tb import rs_types_pkg::*; ();

    localparam int STIM_CYCLES = 1500;
    localparam int DRAIN_LIMIT = 200;
    localparam int HIST        = 2048;

    logic                    clock;
    logic                    reset;
    logic [`RS_WAYS-1:0]     disp_valid;
    alu_op_t [`RS_WAYS-1:0]  disp_op;
    prf_tag_t [`RS_WAYS-1:0] disp_src1_tag;
    prf_tag_t [`RS_WAYS-1:0] disp_src2_tag;
    logic [`RS_WAYS-1:0]     disp_use_imm;
    xlen_t [`RS_WAYS-1:0]    disp_imm;
    prf_tag_t [`RS_WAYS-1:0] disp_dest_tag;
    rs_count_t               free_count;
    logic [`RS_WAYS-1:0]     cdb_valid;
    prf_tag_t [`RS_WAYS-1:0] cdb_tag;
    xlen_t [`RS_WAYS-1:0]    cdb_data;

    // one value and pending flag per tag in the model
    logic    pending [`RS_PRF];
    xlen_t   value   [`RS_PRF];
    // in-flight instructions indexed by dest tag
    alu_op_t rec_op      [`RS_PRF];
    logic    rec_a_known [`RS_PRF];
    xlen_t   rec_a_val   [`RS_PRF];
    int      rec_a_tag   [`RS_PRF];
    logic    rec_b_known [`RS_PRF];
    xlen_t   rec_b_val   [`RS_PRF];
    int      rec_b_tag   [`RS_PRF];

    // per-edge allocation and release counts for free_count
    int        disp_at [HIST];
    int        rel_at  [HIST];
    rs_count_t fc_hist [HIST];

    // tags on the cdb this cycle as bypass candidates
    int byp_tag [`RS_WAYS];
    int byp_n;

    integer seed = 48;
    int errors;
    int checks;
    int cyc;
    int outstanding;
    int cum_disp;
    int cum_rel;
    int byp_cnt;
    int chain_cnt;
    int mul_cnt;
    int imm_cnt;
    int wait_cnt;

    rs_top rs_top_i (
        .clock         (clock),
        .reset         (reset),
        .disp_valid    (disp_valid),
        .disp_op       (disp_op),
        .disp_src1_tag (disp_src1_tag),
        .disp_src2_tag (disp_src2_tag),
        .disp_use_imm  (disp_use_imm),
        .disp_imm      (disp_imm),
        .disp_dest_tag (disp_dest_tag),
        .free_count    (free_count),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_data      (cdb_data)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic int pick(input int n);
        pick = int'($unsigned($random(seed)) % n);
    endfunction

    // expected result from the operation rules
    function automatic xlen_t compute_result(input alu_op_t op, input xlen_t a, input xlen_t b);
        case (op)
            `RS_OP_ADD: compute_result = a + b;
            `RS_OP_SUB: compute_result = a - b;
            `RS_OP_XOR: compute_result = a ^ b;
            // low word of the product
            default:    compute_result = a * b;
        endcase
    endfunction

    // check each cdb result, retire it and wake its consumers
    task automatic observe_cdb();
        int    t;
        int    rel;
        xlen_t exp_v;
        byp_n = 0;
        fc_hist[cyc] = free_count;
        for (int c = 0; c < `RS_WAYS; c++) begin
            if (cdb_valid[c]) begin
                t = int'(cdb_tag[c]);
                checks++;
                assert (pending[t]) else begin
                    $display("result for tag %0d arrived with no instruction outstanding", t);
                    errors++;
                end
                if (pending[t]) begin
                    checks++;
                    assert (rec_a_known[t] && rec_b_known[t]) else begin
                        $display("tag %0d completed before its operands were produced", t);
                        errors++;
                    end
                    exp_v = compute_result(rec_op[t], rec_a_val[t], rec_b_val[t]);
                    checks++;
                    assert (cdb_data[c] == exp_v) else begin
                        $display("[FAIL] cdb_data[%0d] tag %h: got %h expected %h",
                                 c, t, cdb_data[c], exp_v);
                        errors++;
                    end
                    // mul results trail their release edge
                    rel = cyc - ((rec_op[t] == `RS_OP_MUL) ? (`RS_MUL_CYCLES - 1) : 0);
                    if (rel >= 0) begin
                        rel_at[rel]++;
                    end
                    value[t]   = exp_v;
                    pending[t] = 1'b0;
                    outstanding--;
                    for (int r = 0; r < `RS_PRF; r++) begin
                        if (pending[r] && !rec_a_known[r] && rec_a_tag[r] == t) begin
                            rec_a_known[r] = 1'b1;
                            rec_a_val[r]   = exp_v;
                        end
                        if (pending[r] && !rec_b_known[r] && rec_b_tag[r] == t) begin
                            rec_b_known[r] = 1'b1;
                            rec_b_val[r]   = exp_v;
                        end
                    end
                    byp_tag[byp_n] = t;
                    byp_n++;
                end
            end
        end
    endtask

    // free_count checked once every release of that edge is known
    task automatic check_free_count();
        int j;
        int exp_fc;
        j = cyc - (`RS_MUL_CYCLES - 1);
        if (j >= 0) begin
            cum_disp += disp_at[j];
            cum_rel  += rel_at[j];
            exp_fc = `RS_ENTRIES - cum_disp + cum_rel;
            checks++;
            assert (int'(fc_hist[j]) == exp_fc) else begin
                $display("[FAIL] free_count at cycle %0d: got %h expected %h",
                         j, fc_hist[j], exp_fc);
                errors++;
            end
        end
    endtask

    task automatic drive_dispatch(input bit send);
        int      n;
        int      d;
        int      s1;
        int      s2;
        int      start;
        bit      from_byp;
        alu_op_t o;
        logic    imm_en;
        xlen_t   imm;
        logic    ak;
        logic    bk;
        xlen_t   av;
        xlen_t   bv;
        disp_valid    = '0;
        disp_op       = '0;
        disp_src1_tag = '0;
        disp_src2_tag = '0;
        disp_use_imm  = '0;
        disp_imm      = '0;
        disp_dest_tag = '0;
        n = 0;
        if (send) begin
            n = pick(`RS_WAYS + 1);
            // never more ways than free entries
            if (n > int'(free_count)) begin
                n = int'(free_count);
            end
        end
        for (int w = 0; w < n; w++) begin
            start = pick(`RS_PRF);
            d = -1;
            for (int i = 0; i < `RS_PRF; i++) begin
                if (d < 0 && !pending[(start + i) % `RS_PRF]) begin
                    d = (start + i) % `RS_PRF;
                end
            end
            if (d >= 0) begin
                from_byp = (byp_n > 0) && (pick(2) == 0);
                s1 = from_byp ? byp_tag[pick(byp_n)] : pick(`RS_PRF);
                s2 = pick(`RS_PRF);
                o = alu_op_t'(pick(4));
                imm_en = (pick(3) == 0);
                imm = xlen_t'($random(seed));
                // sources read before the dest turns pending
                ak = !pending[s1];
                av = value[s1];
                bk = imm_en ? 1'b1 : !pending[s2];
                bv = imm_en ? imm : value[s2];
                if (from_byp && ak) begin
                    byp_cnt++;
                end
                if (!ak || !bk) begin
                    chain_cnt++;
                end
                if (o == `RS_OP_MUL) begin
                    mul_cnt++;
                end
                if (imm_en) begin
                    imm_cnt++;
                end
                rec_op[d]      = o;
                rec_a_known[d] = ak;
                rec_a_val[d]   = av;
                rec_a_tag[d]   = s1;
                rec_b_known[d] = bk;
                rec_b_val[d]   = bv;
                rec_b_tag[d]   = s2;
                pending[d]     = 1'b1;
                outstanding++;
                // captured on the next edge
                disp_at[cyc + 1]++;
                disp_valid[w]    = 1'b1;
                disp_op[w]       = o;
                disp_src1_tag[w] = prf_tag_t'(s1);
                disp_src2_tag[w] = prf_tag_t'(s2);
                disp_use_imm[w]  = imm_en;
                disp_imm[w]      = imm;
                disp_dest_tag[w] = prf_tag_t'(d);
            end
        end
    endtask

    task automatic run_cycle(input bit send);
        @(negedge clock);
        cyc++;
        observe_cdb();
        check_free_count();
        drive_dispatch(send);
    endtask

    initial begin
        reset         = 1'b1;
        disp_valid    = '0;
        disp_op       = '0;
        disp_src1_tag = '0;
        disp_src2_tag = '0;
        disp_use_imm  = '0;
        disp_imm      = '0;
        disp_dest_tag = '0;
        for (int r = 0; r < `RS_PRF; r++) begin
            pending[r] = 1'b0;
            value[r]   = '0;
        end
        repeat (8) @(negedge clock);
        reset = 1'b0;
        cyc = 0;
        fc_hist[0] = free_count;
        checks += 2;
        assert (free_count == rs_count_t'(`RS_ENTRIES)) else begin
            $display("[FAIL] free_count after reset: got %h expected %h",
                     free_count, `RS_ENTRIES);
            errors++;
        end
        assert (cdb_valid == '0) else begin
            $display("[FAIL] cdb_valid after reset: got %h expected 0", cdb_valid);
            errors++;
        end
        repeat (STIM_CYCLES) run_cycle(1'b1);
        // drain until every dispatched tag has come back
        wait_cnt = 0;
        while (outstanding != 0 && wait_cnt < DRAIN_LIMIT) begin
            run_cycle(1'b0);
            wait_cnt++;
        end
        if (outstanding != 0) begin
            $display("timed out waiting for %0d results to drain", outstanding);
            errors++;
        end
        // lagged free_count checks catch up
        repeat (`RS_MUL_CYCLES) run_cycle(1'b0);
        checks++;
        assert (free_count == rs_count_t'(`RS_ENTRIES)) else begin
            $display("[FAIL] free_count after drain: got %h expected %h",
                     free_count, `RS_ENTRIES);
            errors++;
        end
        checks += 3;
        assert (byp_cnt > 0) else begin
            $display("no dispatch took an operand from a same-cycle cdb result");
            errors++;
        end
        assert (chain_cnt > 0) else begin
            $display("no dispatch depended on a pending result");
            errors++;
        end
        assert (mul_cnt > 0 && imm_cnt > 0) else begin
            $display("stimulus never sent a mul or an immediate");
            errors++;
        end
        $display("checks %0d errors %0d bypass %0d chained %0d mul %0d imm %0d",
                 checks, errors, byp_cnt, chain_cnt, mul_cnt, imm_cnt);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+design
design/rs_types_pkg.sv
design/rs_ctrl_pkg.sv
design/dispatch_if.sv
design/issue_if.sv
design/dispatch_stage.sv
design/rs_entry.sv
design/reservation_station.sv
design/exec_lanes.sv
design/rs_top.sv
test/rs_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the reservation station testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module rs_tb -o rs_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/rs_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TESTS PASSED$"; then
    exit 0
fi
exit 1
